//--- source/pinmux_settings.svh
//--------------------------------------------------
// GPIO pin-mux settings
// Bus widths, register count, chip identity fields
//--------------------------------------------------
`ifndef PINMUX_SETTINGS_SVH
`define PINMUX_SETTINGS_SVH

// Bus and register map
`define PINMUX_DW          32      // Data and GPIO width
`define PINMUX_AW          8       // APB address width
`define PINMUX_NREG        10      // Mapped registers

// Chip identity fields, MSB first
`define PINMUX_MANU_ID     16'h8268  // Manufacturer
`define PINMUX_CORE_CNT    4'h2      // Core count
`define PINMUX_CHIP_NUM    4'h3      // Chip number
`define PINMUX_CHIP_REV    8'h01     // Revision

// Input synchronizer
`define PINMUX_SYNC_STAGES 2       // Flops before capture

`endif

//--- source/pinmux_pkg.sv
//--------------------------------------------------
// GPIO pin-mux types
// Register indices, slave states and bus structs
//--------------------------------------------------
`default_nettype none
`include "pinmux_settings.svh"

package pinmux_pkg;

   // Register word index, paddr[5:2]
   typedef enum logic [3:0] {
      REG_CHIP_ID    = 4'd0,
      REG_GLBL_CTRL  = 4'd1,
      REG_GPIO_IN    = 4'd2,
      REG_GPIO_OUT   = 4'd3,
      REG_GPIO_DIR   = 4'd4,
      REG_INT_STATUS = 4'd5,   // W1C
      REG_INT_SET    = 4'd6,   // W1S
      REG_INT_MASK   = 4'd7,
      REG_POS_SEL    = 4'd8,
      REG_NEG_SEL    = 4'd9
   } reg_index_e;

   typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_DONE} apb_state_e;

   // One-cycle request from the bus front end
   typedef struct packed {
      logic                      wr;     // Mapped write, pready cycle only
      reg_index_e                index;  // Valid for whole transfer
      logic [`PINMUX_DW-1:0]     wdata;
      logic [`PINMUX_DW/8-1:0]   be;
   } reg_req_t;

   typedef struct packed {
      logic [`PINMUX_DW-1:0] out_data;
      logic [`PINMUX_DW-1:0] dir_sel;
      logic [`PINMUX_DW-1:0] posedge_sel;
      logic [`PINMUX_DW-1:0] negedge_sel;
   } gpio_cfg_t;

   // Peripheral resets, all active low
   typedef struct packed {
      logic [1:0] cpu_core_rst_n;
      logic       cpu_intf_rst_n;
      logic       qspim_rst_n;
      logic       sspim_rst_n;
      logic       uart_rst_n;
      logic       i2cm_rst_n;
      logic       usb_rst_n;
   } rst_ctrl_t;

endpackage

`default_nettype wire

//--- source/pinmux_apb_slave.sv
//--------------------------------------------------
// GPIO pin-mux APB slave engine
// One wait state, address check, error response
//--------------------------------------------------
`default_nettype none
`include "pinmux_settings.svh"

module pinmux_apb_slave import pinmux_pkg::*; (
   input  logic                    mclk,
   input  logic                    h_reset_n,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [`PINMUX_AW-1:0]   paddr,
   input  logic [`PINMUX_DW-1:0]   pwdata,
   input  logic [`PINMUX_DW/8-1:0] pstrb,
   input  logic [`PINMUX_DW-1:0]   rd_data,
   output logic [`PINMUX_DW-1:0]   prdata,
   output logic                    pready,
   output logic                    pslverr,
   output reg_req_t                req
);

   apb_state_e  state;
   logic [3:0]  addr_idx;    // Word index
   logic        addr_err;    // Unmapped address

   assign addr_idx = paddr[5:2];
   // Upper address bits must be clear too
   assign addr_err = (paddr[`PINMUX_AW-1:6] != '0) || (addr_idx >= `PINMUX_NREG);

   //--------------------------------------------------
   // Transfer sequencing
   //--------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         state  <= ST_IDLE;
         prdata <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE : if (psel && !penable) state <= ST_WAIT;   // Setup seen
            ST_WAIT :
            begin
               prdata <= addr_err ? '0 : rd_data;   // Capture read path
               state  <= ST_DONE;
            end
            default : state <= ST_IDLE;   // ST_DONE, pready cycle
         endcase
      end
   end

   assign pready  = (state == ST_DONE);
   assign pslverr = (state == ST_DONE) && addr_err;

   // Request to register blocks
   assign req.wr    = pready && psel && pwrite && !addr_err;
   assign req.index = reg_index_e'(addr_idx);
   assign req.wdata = pwdata;
   assign req.be    = pstrb;

endmodule

`default_nettype wire

//--- source/pinmux_cfg_regs.sv
//--------------------------------------------------
// GPIO pin-mux configuration registers
// Byte-strobed storage, identity word, read mux
//--------------------------------------------------
`default_nettype none
`include "pinmux_settings.svh"

module pinmux_cfg_regs import pinmux_pkg::*; (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  reg_req_t              req,
   input  logic [`PINMUX_DW-1:0] gpio_data_in,
   input  logic [`PINMUX_DW-1:0] int_status,
   output logic [`PINMUX_DW-1:0] rd_data,
   output rst_ctrl_t             rst_ctrl,
   output gpio_cfg_t             gpio_cfg,
   output logic [`PINMUX_DW-1:0] int_mask
);

   localparam logic [`PINMUX_DW-1:0] CHIP_ID =
      {`PINMUX_MANU_ID, `PINMUX_CORE_CNT, `PINMUX_CHIP_NUM, `PINMUX_CHIP_REV};

   logic [`PINMUX_DW-1:0] glbl_ctrl;   // Peripheral reset bits
   logic [`PINMUX_DW-1:0] gpio_out;
   logic [`PINMUX_DW-1:0] gpio_dir;    // 1 drives the pad
   logic [`PINMUX_DW-1:0] mask_q;
   logic [`PINMUX_DW-1:0] pos_sel;
   logic [`PINMUX_DW-1:0] neg_sel;

   // Replace only the strobed bytes
   function automatic logic [`PINMUX_DW-1:0] byte_merge(
      input logic [`PINMUX_DW-1:0]   old_val,
      input logic [`PINMUX_DW-1:0]   new_val,
      input logic [`PINMUX_DW/8-1:0] be
   );
      logic [`PINMUX_DW-1:0] res;
      res = old_val;
      for (int b = 0; b < `PINMUX_DW/8; b++)
      begin
         if (be[b])
            res[b*8 +: 8] = new_val[b*8 +: 8];
      end
      return res;
   endfunction

   //--------------------------------------------------
   // Register writes
   //--------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         glbl_ctrl <= '0;   // All peripherals held in reset
         gpio_out  <= '0;
         gpio_dir  <= '0;
         mask_q    <= '0;
         pos_sel   <= '0;
         neg_sel   <= '0;
      end
      else if (req.wr)
      begin
         case (req.index)
            REG_GLBL_CTRL : glbl_ctrl <= byte_merge(glbl_ctrl, req.wdata, req.be);
            REG_GPIO_OUT  : gpio_out  <= byte_merge(gpio_out, req.wdata, req.be);
            REG_GPIO_DIR  : gpio_dir  <= byte_merge(gpio_dir, req.wdata, req.be);
            REG_INT_MASK  : mask_q    <= byte_merge(mask_q, req.wdata, req.be);
            REG_POS_SEL   : pos_sel   <= byte_merge(pos_sel, req.wdata, req.be);
            REG_NEG_SEL   : neg_sel   <= byte_merge(neg_sel, req.wdata, req.be);
            default       : ;   // Read-only or handled in status block
         endcase
      end
   end

   // Reset fan-out
   assign rst_ctrl.cpu_intf_rst_n = glbl_ctrl[0];
   assign rst_ctrl.qspim_rst_n    = glbl_ctrl[1];
   assign rst_ctrl.sspim_rst_n    = glbl_ctrl[2];
   assign rst_ctrl.uart_rst_n     = glbl_ctrl[3];
   assign rst_ctrl.i2cm_rst_n     = glbl_ctrl[4];
   assign rst_ctrl.usb_rst_n      = glbl_ctrl[5];
   assign rst_ctrl.cpu_core_rst_n = glbl_ctrl[9:8];

   assign gpio_cfg = '{out_data: gpio_out, dir_sel: gpio_dir,
                       posedge_sel: pos_sel, negedge_sel: neg_sel};
   assign int_mask = mask_q;

   //--------------------------------------------------
   // Read multiplexer
   //--------------------------------------------------
   always_comb
   begin
      case (req.index)
         REG_CHIP_ID    : rd_data = CHIP_ID;
         REG_GLBL_CTRL  : rd_data = glbl_ctrl;
         REG_GPIO_IN    : rd_data = gpio_data_in;   // Synchronized pins
         REG_GPIO_OUT   : rd_data = gpio_out;
         REG_GPIO_DIR   : rd_data = gpio_dir;
         REG_INT_STATUS,
         REG_INT_SET    : rd_data = int_status;     // Both alias status
         REG_INT_MASK   : rd_data = mask_q;
         REG_POS_SEL    : rd_data = pos_sel;
         REG_NEG_SEL    : rd_data = neg_sel;
         default        : rd_data = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- source/gpio_in_sync.sv
//--------------------------------------------------
// GPIO input synchronizer
// Flop chain plus capture stage for edge detect
//--------------------------------------------------
`default_nettype none
`include "pinmux_settings.svh"

module gpio_in_sync (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  logic [`PINMUX_DW-1:0] gpio_in_data,       // Async pins
   output logic [`PINMUX_DW-1:0] gpio_data_in,       // Current sample
   output logic [`PINMUX_DW-1:0] gpio_prev_indata    // One cycle younger
);

   localparam int N = `PINMUX_SYNC_STAGES;

   logic [N-1:0][`PINMUX_DW-1:0] sync_q;   // [0] is metastable stage

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         sync_q       <= '0;
         gpio_data_in <= '0;
      end
      else
      begin
         sync_q[0] <= gpio_in_data;
         for (int i = 1; i < N; i++)
            sync_q[i] <= sync_q[i-1];
         gpio_data_in <= sync_q[N-1];   // Capture
      end
   end

   assign gpio_prev_indata = sync_q[N-1];

endmodule

`default_nettype wire

//--- source/gpio_int_status.sv
//--------------------------------------------------
// GPIO interrupt status
// W1C and W1S per byte, hardware events win
//--------------------------------------------------
`default_nettype none
`include "pinmux_settings.svh"

module gpio_int_status import pinmux_pkg::*; (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  reg_req_t              req,
   input  logic [`PINMUX_DW-1:0] gpio_int_event,
   input  logic [`PINMUX_DW-1:0] int_mask,
   output logic [`PINMUX_DW-1:0] int_status,
   output logic                  gpio_intr
);

   localparam int NB = `PINMUX_DW / 8;

   logic                  clr_en;       // Write to status index
   logic                  set_en;       // Write to set index
   logic [`PINMUX_DW-1:0] status_nxt;

   assign clr_en = req.wr && (req.index == REG_INT_STATUS);
   assign set_en = req.wr && (req.index == REG_INT_SET);

   always_comb
   begin
      status_nxt = int_status;   // Hold by default
      for (int b = 0; b < NB; b++)
      begin
         if (clr_en && req.be[b])
            status_nxt[b*8 +: 8] = int_status[b*8 +: 8] & ~req.wdata[b*8 +: 8];
         else if (set_en && req.be[b])
            status_nxt[b*8 +: 8] = int_status[b*8 +: 8] | req.wdata[b*8 +: 8];
      end
      // New events override a software clear
      status_nxt = status_nxt | gpio_int_event;
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         int_status <= '0;
      else
         int_status <= status_nxt;
   end

   assign gpio_intr = |(int_status & int_mask);   // Combined line to CPU

endmodule

`default_nettype wire

//--- source/pinmux_top.sv
//--------------------------------------------------
// GPIO pin-mux control block, top level
// APB front end, config, input sync, int status
//--------------------------------------------------
`default_nettype none
`include "pinmux_settings.svh"

module pinmux_top import pinmux_pkg::*; (
   input  logic                    mclk,
   input  logic                    h_reset_n,
   // APB slave
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [`PINMUX_AW-1:0]   paddr,
   input  logic [`PINMUX_DW-1:0]   pwdata,
   input  logic [`PINMUX_DW/8-1:0] pstrb,
   output logic [`PINMUX_DW-1:0]   prdata,
   output logic                    pready,
   output logic                    pslverr,
   // GPIO side
   input  logic [`PINMUX_DW-1:0]   gpio_in_data,
   input  logic [`PINMUX_DW-1:0]   gpio_int_event,
   output rst_ctrl_t               rst_ctrl,
   output gpio_cfg_t               gpio_cfg,
   output logic [`PINMUX_DW-1:0]   gpio_data_in,
   output logic [`PINMUX_DW-1:0]   gpio_prev_indata,
   output logic                    gpio_intr
);

   reg_req_t              req;
   logic [`PINMUX_DW-1:0] rd_data;     // Read mux result
   logic [`PINMUX_DW-1:0] int_status;
   logic [`PINMUX_DW-1:0] int_mask;

   pinmux_apb_slave u_apb_slave (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .pstrb     (pstrb),
      .rd_data   (rd_data),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .req       (req)
   );

   pinmux_cfg_regs u_cfg_regs (
      .mclk         (mclk),
      .h_reset_n    (h_reset_n),
      .req          (req),
      .gpio_data_in (gpio_data_in),
      .int_status   (int_status),
      .rd_data      (rd_data),
      .rst_ctrl     (rst_ctrl),
      .gpio_cfg     (gpio_cfg),
      .int_mask     (int_mask)
   );

   gpio_in_sync u_in_sync (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .gpio_in_data     (gpio_in_data),
      .gpio_data_in     (gpio_data_in),
      .gpio_prev_indata (gpio_prev_indata)
   );

   gpio_int_status u_int_status (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .req            (req),
      .gpio_int_event (gpio_int_event),
      .int_mask       (int_mask),
      .int_status     (int_status),
      .gpio_intr      (gpio_intr)
   );

endmodule

`default_nettype wire

//--- verification/pinmux_tb.sv
//--------------------------------------------------
// GPIO pin-mux testbench
// Directed APB tests checked against a register model
//--------------------------------------------------
`default_nettype none
`include "pinmux_settings.svh"

module pinmux_tb import pinmux_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ns;

   localparam int MAX_CYCLES = 2000;   // About 70 transfers of 4 cycles, wide margin

   logic                    mclk;
   logic                    h_reset_n;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [`PINMUX_AW-1:0]   paddr;
   logic [`PINMUX_DW-1:0]   pwdata;
   logic [`PINMUX_DW/8-1:0] pstrb;
   logic [`PINMUX_DW-1:0]   prdata;
   logic                    pready;
   logic                    pslverr;
   logic [`PINMUX_DW-1:0]   gpio_in_data;
   logic [`PINMUX_DW-1:0]   gpio_int_event;
   rst_ctrl_t               rst_ctrl;
   gpio_cfg_t               gpio_cfg;
   logic [`PINMUX_DW-1:0]   gpio_data_in;
   logic [`PINMUX_DW-1:0]   gpio_prev_indata;
   logic                    gpio_intr;

   int          errors = 0;
   int          checks = 0;
   int          cycle_cnt = 0;
   logic [31:0] model [0:`PINMUX_NREG-1];   // Expected contents by word index

   pinmux_top pinmux_top_i (.*);

   initial mclk = 1'b0;
   always #50 mclk = ~mclk;   // 100 ns period

   //--------------------------------------------------
   // Watchdog
   //--------------------------------------------------
   always @(posedge mclk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // Byte lanes enabled by strobes
   function automatic logic [31:0] lane_mask(input logic [3:0] strb);
      return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
   endfunction

   // Struct order, cores MSB then intf, qspim, sspim, uart, i2cm, usb
   function automatic logic [7:0] expected_rst(input logic [31:0] glbl);
      return {glbl[9:8], glbl[0], glbl[1], glbl[2], glbl[3], glbl[4], glbl[5]};
   endfunction

   function automatic logic [31:0] expected_read(input logic [3:0] idx);
      if (idx == REG_INT_SET)
         return model[REG_INT_STATUS];   // Set index reads status
      return model[idx];
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         $display("** Error [%s] expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic model_write(input logic [3:0] idx, input logic [31:0] data,
                              input logic [3:0] strb);
      logic [31:0] m;
      m = lane_mask(strb);
      case (idx)
         REG_INT_STATUS : model[REG_INT_STATUS] = model[REG_INT_STATUS] & ~(data & m);   // W1C
         REG_INT_SET    : model[REG_INT_STATUS] = model[REG_INT_STATUS] | (data & m);    // W1S
         REG_GLBL_CTRL, REG_GPIO_OUT, REG_GPIO_DIR, REG_INT_MASK, REG_POS_SEL, REG_NEG_SEL :
            model[idx] = (model[idx] & ~m) | (data & m);
         default        : ;   // Read-only or unmapped
      endcase
   endtask

   //--------------------------------------------------
   // APB master
   //--------------------------------------------------
   task automatic apb_transfer(input logic wr, input logic [3:0] idx, input logic [31:0] data,
                               input logic [3:0] strb, output logic [31:0] rdata,
                               output logic err);
      @(negedge mclk);
      psel    = 1'b1;   // Setup
      penable = 1'b0;
      pwrite  = wr;
      paddr   = {2'b00, idx, 2'b00};
      pwdata  = data;
      pstrb   = strb;
      @(negedge mclk);
      penable = 1'b1;   // Access
      @(negedge mclk);
      while (!pready)
         @(negedge mclk);
      rdata = prdata;
      err   = pslverr;
      @(negedge mclk);   // Pready cycle over, write committed
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [3:0] idx, input logic [31:0] data,
                            input logic [3:0] strb, output logic err);
      logic [31:0] unused_rd;
      apb_transfer(1'b1, idx, data, strb, unused_rd, err);
      if (idx < `PINMUX_NREG)
         model_write(idx, data, strb);
   endtask

   task automatic read_check(input string name, input logic [3:0] idx);
      logic [31:0] rd;
      logic        err;
      apb_transfer(1'b0, idx, '0, 4'h0, rd, err);
      check_value(name, expected_read(idx), rd);
      check_value({name, " pslverr"}, 32'd0, {31'b0, err});
   endtask

   task automatic check_outputs(input string name);
      check_value({name, " rst_ctrl"}, {24'h0, expected_rst(model[REG_GLBL_CTRL])},
                  {24'h0, rst_ctrl});
      check_value({name, " out_data"}, model[REG_GPIO_OUT], gpio_cfg.out_data);
      check_value({name, " dir_sel"}, model[REG_GPIO_DIR], gpio_cfg.dir_sel);
      check_value({name, " posedge_sel"}, model[REG_POS_SEL], gpio_cfg.posedge_sel);
      check_value({name, " negedge_sel"}, model[REG_NEG_SEL], gpio_cfg.negedge_sel);
      check_value({name, " gpio_intr"},
                  {31'b0, |(model[REG_INT_STATUS] & model[REG_INT_MASK])}, {31'b0, gpio_intr});
   endtask

   //--------------------------------------------------
   // Directed tests
   //--------------------------------------------------
   task automatic reset_and_identity();
      check_outputs("after reset");   // Model is all zero here
      read_check("chip id", REG_CHIP_ID);
   endtask

   task automatic config_registers();
      reg_index_e regs [0:4];
      logic       err;
      regs = '{REG_GLBL_CTRL, REG_GPIO_OUT, REG_GPIO_DIR, REG_POS_SEL, REG_NEG_SEL};
      repeat (3)
      begin
         for (int r = 0; r < 5; r++)
         begin
            apb_write(regs[r], $urandom(), 4'($urandom()), err);   // Random strobes
            check_value("cfg write pslverr", 32'd0, {31'b0, err});
            read_check($sformatf("cfg reg %0d", regs[r]), regs[r]);
            check_outputs("cfg outputs");
         end
      end
   endtask

   task automatic gpio_input();
      repeat (2)
      begin
         @(negedge mclk);
         gpio_in_data = $urandom();
         model[REG_GPIO_IN] = gpio_in_data;
         repeat (4) @(negedge mclk);   // Past 3-cycle latency
         check_value("gpio_data_in", model[REG_GPIO_IN], gpio_data_in);
         check_value("gpio_prev_indata", model[REG_GPIO_IN], gpio_prev_indata);
         read_check("gpio in read", REG_GPIO_IN);
      end
   endtask

   task automatic interrupt_set_clear();
      logic err;
      repeat (4)
      begin
         apb_write(REG_INT_SET, $urandom(), 4'($urandom()), err);
         read_check("int set status", REG_INT_STATUS);
         read_check("int set alias", REG_INT_SET);
         apb_write(REG_INT_MASK, $urandom(), 4'hF, err);
         check_outputs("int mask");
         apb_write(REG_INT_STATUS, $urandom(), 4'($urandom()), err);
         read_check("int clear status", REG_INT_STATUS);
         read_check("int clear alias", REG_INT_SET);
         check_outputs("int clear");
      end
      apb_write(REG_INT_STATUS, '1, 4'hF, err);   // Clear all
      check_outputs("int all clear");
   endtask

   task automatic event_priority();
      logic err;
      @(negedge mclk);
      gpio_int_event[5] = 1'b1;
      @(negedge mclk);   // One capture edge
      model[REG_INT_STATUS][5] = 1'b1;
      read_check("event capture", REG_INT_STATUS);
      apb_write(REG_INT_STATUS, 32'h20, 4'h1, err);   // Clear while event held
      gpio_int_event[5] = 1'b0;   // Gone before the next edge
      model[REG_INT_STATUS][5] = 1'b1;   // Event wins over the clear
      read_check("clear under event", REG_INT_STATUS);
      read_check("event dropped", REG_INT_STATUS);
      apb_write(REG_INT_STATUS, 32'h20, 4'h1, err);
      read_check("clear after event", REG_INT_STATUS);
      check_outputs("event priority");
   endtask

   task automatic unmapped_address();
      logic [31:0] rd;
      logic        err;
      apb_write(4'd12, $urandom(), 4'hF, err);
      check_value("unmapped write pslverr", 32'd1, {31'b0, err});
      apb_transfer(1'b0, 4'd12, '0, 4'h0, rd, err);
      check_value("unmapped read data", 32'd0, rd);
      check_value("unmapped read pslverr", 32'd1, {31'b0, err});
      for (int i = 0; i < `PINMUX_NREG; i++)
         read_check($sformatf("reg %0d after unmapped", i), 4'(i));
      check_outputs("after unmapped");
   endtask

   initial
   begin
      void'($urandom(6156));   // Seed once
      h_reset_n      = 1'b0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      pstrb          = '0;
      gpio_in_data   = '0;
      gpio_int_event = '0;
      foreach (model[i])
         model[i] = '0;
      model[REG_CHIP_ID] = {`PINMUX_MANU_ID, `PINMUX_CORE_CNT, `PINMUX_CHIP_NUM,
                            `PINMUX_CHIP_REV};
      repeat (10) @(negedge mclk);
      h_reset_n = 1'b1;
      reset_and_identity();
      config_registers();
      gpio_input();
      interrupt_set_clear();
      event_priority();
      unmapped_address();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/pinmux_pkg.sv
source/pinmux_apb_slave.sv
source/pinmux_cfg_regs.sv
source/gpio_in_sync.sv
source/gpio_int_status.sv
source/pinmux_top.sv
verification/pinmux_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the pin-mux testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f list.f --top-module pinmux_tb -o pinmux_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/pinmux_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi
echo "Simulation passed"
exit 0
